// ==== hdl/procPkg.sv ====
`default_nettype none

package procPkg;

    // Word and register file sizes
    localparam int dataWidth = 16;
    localparam int regCount = 8;
    localparam int regAddrWidth = 3;

    // Memory depths in words, upper address bits are ignored
    localparam int imemDepth = 256;
    localparam int dmemDepth = 256;
    localparam int imemAddrWidth = $clog2(imemDepth);
    localparam int dmemAddrWidth = $clog2(dmemDepth);

    // Five-bit opcodes in instr[15:11]
    typedef enum logic [4:0] {
        HALT  = 5'b00000,
        NOP   = 5'b00001,
        J     = 5'b00100,
        ADDI  = 5'b01000,
        SUBI  = 5'b01001,
        XORI  = 5'b01010,
        ANDNI = 5'b01011,
        BEQZ  = 5'b01100,
        BNEZ  = 5'b01101,
        ST    = 5'b10000,
        LD    = 5'b10001,
        LBI   = 5'b11000,
        RRR   = 5'b11011
    } opcodeE;

    // ALU operations, sub is B minus A and andn is A and not B
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_ANDN,
        ALU_PASSB
    } aluOpE;

    // Immediate formats
    typedef enum logic [1:0] {
        IMM_SEXT5,
        IMM_ZEXT5,
        IMM_SEXT8
    } immKindE;

endpackage

`default_nettype wire

// ==== hdl/ctrlIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface ctrlIf import procPkg::*; ();

    logic    regWrite;
    logic    memWrite;
    logic    memToReg;
    logic    aluSrc;
    logic    branchZero;
    logic    branchNotZero;
    logic    jump;
    logic    halt;
    logic    illegal;
    immKindE immKind;
    aluOpE   aluOp;

    modport dec (
        output regWrite, memWrite, memToReg, aluSrc, branchZero, branchNotZero,
        output jump, halt, illegal, immKind, aluOp
    );
    modport regs (input regWrite, immKind);
    modport alu (input aluSrc, aluOp);
    modport mem (input memWrite, memToReg);
    modport pc (input branchZero, branchNotZero, jump);

endinterface

`default_nettype wire

// ==== hdl/fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch import procPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 run,
    input  logic                 loadEn,
    input  logic [dataWidth-1:0] loadAddr,
    input  logic [dataWidth-1:0] loadData,
    input  logic [dataWidth-1:0] nextPc,
    input  logic                 stop,
    input  logic                 illegal,
    output logic [dataWidth-1:0] pc,
    output logic [dataWidth-1:0] instr,
    output logic                 halted,
    output logic                 err
);

    logic [dataWidth-1:0] imem [imemDepth];
    logic                 stepping;

    assign stepping = run && !halted;

    // Load port takes a word index
    always_ff @(posedge clk) begin
        if (loadEn) begin
            imem[loadAddr[imemAddrWidth-1:0]] <= loadData;
        end
    end

    // PC is a byte address, bit 0 is dropped for the word read
    assign instr = imem[pc[imemAddrWidth:1]];

    always_ff @(posedge clk) begin
        if (rst) begin
            pc     <= '0;
            halted <= 1'b0;
            err    <= 1'b0;
        end else if (!run) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (stepping) begin
            if (stop) begin
                halted <= 1'b1;
            end else begin
                pc <= nextPc;
            end
            // Sticky until reset
            if (illegal) begin
                err <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/control.sv ====
`timescale 1ns/1ps
`default_nettype none

module control import procPkg::*; (
    input  opcodeE      opcode,
    input  logic [1:0]  funct,
    input  logic        active,
    ctrlIf.dec          ctl
);

    logic regWr;
    logic memWr;

    always_comb begin
        regWr             = 1'b0;
        memWr             = 1'b0;
        ctl.memToReg      = 1'b0;
        ctl.aluSrc        = 1'b0;
        ctl.branchZero    = 1'b0;
        ctl.branchNotZero = 1'b0;
        ctl.jump          = 1'b0;
        ctl.halt          = 1'b0;
        ctl.illegal       = 1'b0;
        ctl.immKind       = IMM_SEXT5;
        ctl.aluOp         = ALU_PASSB;

        case (opcode)
            HALT: ctl.halt = 1'b1;
            NOP:  ;
            J:    ctl.jump = 1'b1;
            ADDI, SUBI, XORI, ANDNI: begin
                regWr      = 1'b1;
                ctl.aluSrc = 1'b1;
                if (opcode == XORI || opcode == ANDNI) begin
                    ctl.immKind = IMM_ZEXT5;
                end
                case (opcode)
                    ADDI:    ctl.aluOp = ALU_ADD;
                    SUBI:    ctl.aluOp = ALU_SUB;
                    XORI:    ctl.aluOp = ALU_XOR;
                    default: ctl.aluOp = ALU_ANDN;
                endcase
            end
            BEQZ, BNEZ: begin
                ctl.immKind       = IMM_SEXT8;
                ctl.branchZero    = (opcode == BEQZ);
                ctl.branchNotZero = (opcode == BNEZ);
            end
            ST, LD: begin
                // Address is Rs plus the sign-extended offset
                ctl.aluSrc   = 1'b1;
                ctl.aluOp    = ALU_ADD;
                memWr        = (opcode == ST);
                regWr        = (opcode == LD);
                ctl.memToReg = (opcode == LD);
            end
            LBI: begin
                regWr       = 1'b1;
                ctl.aluSrc  = 1'b1;
                ctl.immKind = IMM_SEXT8;
            end
            RRR: begin
                regWr = 1'b1;
                case (funct)
                    2'b00:   ctl.aluOp = ALU_ADD;
                    2'b01:   ctl.aluOp = ALU_SUB;
                    2'b10:   ctl.aluOp = ALU_XOR;
                    default: ctl.aluOp = ALU_ANDN;
                endcase
            end
            default: begin
                ctl.illegal = 1'b1;
                ctl.halt    = 1'b1;
            end
        endcase

        // No state changes unless the core is stepping
        ctl.regWrite = regWr && active;
        ctl.memWrite = memWr && active;
    end

endmodule

`default_nettype wire

// ==== hdl/decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode import procPkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [dataWidth-1:0]    instr,
    input  logic [dataWidth-1:0]    writeData,
    ctrlIf.regs                     ctl,
    output logic [dataWidth-1:0]    readA,
    output logic [dataWidth-1:0]    readB,
    output logic [dataWidth-1:0]    imm,
    output logic [regAddrWidth-1:0] wbReg
);

    logic [dataWidth-1:0] regs [regCount];
    opcodeE               opcode;

    assign opcode = opcodeE'(instr[15:11]);

    // Rs and Rt read ports
    assign readA = regs[instr[10:8]];
    assign readB = regs[instr[7:5]];

    // Destination is Rd for RRR, Rs for LBI and Rt for I1
    always_comb begin
        if (opcode == RRR) begin
            wbReg = instr[4:2];
        end else if (opcode == LBI) begin
            wbReg = instr[10:8];
        end else begin
            wbReg = instr[7:5];
        end
    end

    always_comb begin
        case (ctl.immKind)
            IMM_ZEXT5: imm = {11'b0, instr[4:0]};
            IMM_SEXT8: imm = {{8{instr[7]}}, instr[7:0]};
            default:   imm = {{11{instr[4]}}, instr[4:0]};
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (ctl.regWrite) begin
            regs[wbReg] <= writeData;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute import procPkg::*; (
    input  logic [dataWidth-1:0] readA,
    input  logic [dataWidth-1:0] readB,
    input  logic [dataWidth-1:0] imm,
    ctrlIf.alu                   ctl,
    output logic [dataWidth-1:0] result,
    output logic                 zero
);

    logic [dataWidth-1:0] opB;

    assign opB = ctl.aluSrc ? imm : readB;

    always_comb begin
        case (ctl.aluOp)
            ALU_ADD:   result = readA + opB;
            // Reversed subtract as in SUBI and SUB
            ALU_SUB:   result = opB - readA;
            ALU_XOR:   result = readA ^ opB;
            ALU_ANDN:  result = readA & ~opB;
            ALU_PASSB: result = opB;
            default:   result = '0;
        endcase
    end

    // Branch condition tests Rs
    assign zero = (readA == '0);

endmodule

`default_nettype wire

// ==== hdl/memStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module memStage import procPkg::*; (
    input  logic                 clk,
    input  logic [dataWidth-1:0] aluResult,
    input  logic [dataWidth-1:0] storeData,
    ctrlIf.mem                   ctl,
    output logic [dataWidth-1:0] writeData
);

    logic [dataWidth-1:0]     dmem [dmemDepth];
    logic [dmemAddrWidth-1:0] addr;

    // Byte address from the ALU, bit 0 dropped
    assign addr = aluResult[dmemAddrWidth:1];

    always_ff @(posedge clk) begin
        if (ctl.memWrite) begin
            dmem[addr] <= storeData;
        end
    end

    // Write-back select
    assign writeData = ctl.memToReg ? dmem[addr] : aluResult;

endmodule

`default_nettype wire

// ==== hdl/pcControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module pcControl import procPkg::*; (
    input  logic [dataWidth-1:0] pc,
    input  logic [dataWidth-1:0] instr,
    input  logic [dataWidth-1:0] imm,
    input  logic                 zero,
    ctrlIf.pc                    ctl,
    output logic [dataWidth-1:0] nextPc
);

    logic [dataWidth-1:0] incPc;
    logic [dataWidth-1:0] target;
    logic [dataWidth-1:0] jumpDisp;
    logic                 taken;

    assign incPc    = pc + 16'd2;
    assign jumpDisp = {{5{instr[10]}}, instr[10:0]};
    assign taken    = (ctl.branchZero && zero) || (ctl.branchNotZero && !zero);

    always_comb begin
        if (ctl.jump) begin
            target = incPc + jumpDisp;
        end else if (taken) begin
            target = incPc + imm;
        end else begin
            target = incPc;
        end
    end

    // Keep the PC word aligned
    assign nextPc = {target[dataWidth-1:1], 1'b0};

endmodule

`default_nettype wire

// ==== hdl/proc.sv ====
`timescale 1ns/1ps
`default_nettype none

module proc import procPkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    run,
    input  logic                    loadEn,
    input  logic [dataWidth-1:0]    loadAddr,
    input  logic [dataWidth-1:0]    loadData,
    output logic                    err,
    output logic                    halted,
    output logic                    wbValid,
    output logic [regAddrWidth-1:0] wbReg,
    output logic [dataWidth-1:0]    wbData
);

    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] instr;
    logic [dataWidth-1:0] nextPc;
    logic [dataWidth-1:0] readA;
    logic [dataWidth-1:0] readB;
    logic [dataWidth-1:0] imm;
    logic [dataWidth-1:0] aluResult;
    logic                 zero;

    ctrlIf ctl ();

    fetch fetch0 (
        .clk(clk), .rst(rst), .run(run),
        .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
        .nextPc(nextPc), .stop(ctl.halt), .illegal(ctl.illegal),
        .pc(pc), .instr(instr), .halted(halted), .err(err)
    );

    control control0 (
        .opcode(opcodeE'(instr[15:11])), .funct(instr[1:0]),
        .active(run && !halted), .ctl(ctl.dec)
    );

    decode decode0 (
        .clk(clk), .rst(rst), .instr(instr), .writeData(wbData), .ctl(ctl.regs),
        .readA(readA), .readB(readB), .imm(imm), .wbReg(wbReg)
    );

    execute exec0 (
        .readA(readA), .readB(readB), .imm(imm), .ctl(ctl.alu),
        .result(aluResult), .zero(zero)
    );

    // Rt is the store data
    memStage mem0 (
        .clk(clk), .aluResult(aluResult), .storeData(readB), .ctl(ctl.mem),
        .writeData(wbData)
    );

    pcControl pcControl0 (
        .pc(pc), .instr(instr), .imm(imm), .zero(zero), .ctl(ctl.pc),
        .nextPc(nextPc)
    );

    // Retire trace follows the gated register write
    assign wbValid = ctl.regWrite;

endmodule

`default_nettype wire

// ==== testbench/proc_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module proc_props import procPkg::*; (
    input logic                 clk,
    input logic                 rst,
    input logic                 run,
    input logic                 halted,
    input logic                 err,
    input logic                 wbValid,
    input logic [dataWidth-1:0] pc
);

    // The instruction that stops the core writes no register
    noTraceWhileHalted: assert property (@(posedge clk) disable iff (rst)
        halted |-> !$past(wbValid))
        else $error("wbValid high in the cycle that halted the core");

    errSticky: assert property (@(posedge clk) $fell(err) |-> $past(rst))
        else $error("err fell without reset");

    pcHoldsWhenHalted: assert property (@(posedge clk) (halted && run && !rst) |=> $stable(pc))
        else $error("PC moved while halted");

endmodule

bind proc proc_props props0 (
    .clk(clk), .rst(rst), .run(run), .halted(halted), .err(err),
    .wbValid(wbValid), .pc(pc)
);

`default_nettype wire

// ==== testbench/tb_proc.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_proc import procPkg::*; ();

    localparam int progWords   = 48;
    localparam int progLength  = 24;
    localparam int numPrograms = 20;
    localparam int maxCycles   = 400;

    logic                    clk;
    logic                    rst;
    logic                    run;
    logic                    loadEn;
    logic [dataWidth-1:0]    loadAddr;
    logic [dataWidth-1:0]    loadData;
    logic                    err;
    logic                    halted;
    logic                    wbValid;
    logic [regAddrWidth-1:0] wbReg;
    logic [dataWidth-1:0]    wbData;

    // Program image and model state
    logic [15:0] prog [progWords];
    logic [15:0] modelRegs [regCount];
    logic [15:0] modelMem [dmemDepth];
    // Expected writes as {reg, value}
    logic [18:0] expTrace [$];
    logic        expErr;
    logic [31:0] rngState;

    proc uut (
        .clk(clk), .rst(rst), .run(run), .loadEn(loadEn), .loadAddr(loadAddr),
        .loadData(loadData), .err(err), .halted(halted), .wbValid(wbValid),
        .wbReg(wbReg), .wbData(wbData)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int randBelow(input int n);
        rngState = xorshift32(rngState);
        return int'(rngState % 32'(n));
    endfunction

    function automatic logic [15:0] encI1(input opcodeE op, input int rs, input int rt,
                                          input int imm);
        return {op, 3'(rs), 3'(rt), 5'(imm)};
    endfunction

    function automatic logic [15:0] encI2(input opcodeE op, input int rs, input int imm);
        return {op, 3'(rs), 8'(imm)};
    endfunction

    function automatic logic [15:0] encRRR(input int rs, input int rt, input int rd,
                                           input int fn);
        return {RRR, 3'(rs), 3'(rt), 3'(rd), 2'(fn)};
    endfunction

    // Opcodes outside the instruction set
    function automatic logic [4:0] illegalOpcode();
        case (randBelow(4))
            0:       return 5'b00010;
            1:       return 5'b00111;
            2:       return 5'b01110;
            default: return 5'b11111;
        endcase
    endfunction

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic expectEqual(input string what, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic padProgram(input int from, input logic [15:0] fill);
        for (int k = from; k < progWords; k++) begin
            prog[k] = fill;
        end
    endtask

    // Writes known values to data words 0 to 15 through base 16 in r7
    task automatic genMemInit();
        prog[0] = encI2(LBI, 7, 16);
        for (int w = 0; w < 16; w++) begin
            prog[1 + 2 * w] = encI2(LBI, 1, randBelow(256));
            prog[2 + 2 * w] = encI1(ST, 7, 1, 2 * w - 16);
        end
        padProgram(33, {HALT, 11'd0});
    endtask

    // r7 only ever holds a small even base and accesses stay in words 0 to 15
    task automatic genProgram(input int n, input logic [15:0] fill);
        int i;
        int pick;
        int off;
        i = 0;
        while (i < n) begin
            pick = randBelow(9);
            if (pick >= 7 && i + 3 > n) begin
                pick = 6;
            end
            case (pick)
                0: prog[i] = encI1(opcodeE'(5'(8 + randBelow(4))), randBelow(8),
                                   randBelow(7), randBelow(32));
                1, 2: prog[i] = encRRR(randBelow(8), randBelow(8), randBelow(7), randBelow(4));
                3: prog[i] = encI2(LBI, randBelow(7), randBelow(256));
                4: prog[i] = encI2(randBelow(2) == 0 ? BEQZ : BNEZ, randBelow(8),
                                   2 * randBelow(4));
                5: prog[i] = {J, 11'(2 * randBelow(4))};
                6: prog[i] = {NOP, 11'd0};
                default: begin
                    off = 2 * randBelow(8);
                    prog[i] = encI2(LBI, 7, 2 * randBelow(9));
                    if (pick == 7) begin
                        prog[i + 1] = encI1(ST, 7, randBelow(8), off);
                        i++;
                    end
                    prog[i + 1] = encI1(LD, 7, randBelow(7), off);
                    i++;
                end
            endcase
            i++;
        end
        padProgram(n, fill);
    endtask

    // Instruction-set model with the PC as a byte address
    task automatic runModel();
        logic [15:0] pc;
        logic [15:0] ins;
        logic [15:0] rs;
        logic [15:0] rt;
        logic [15:0] se5;
        logic [15:0] ze5;
        logic [15:0] se8;
        logic [15:0] addr;
        logic [15:0] val;
        logic [2:0]  dst;
        logic        wr;
        logic        done;
        int          steps;
        expTrace.delete();
        expErr = 1'b0;
        pc = '0;
        done = 1'b0;
        steps = 0;
        while (!done && steps < maxCycles) begin
            ins  = prog[int'(pc[8:1])];
            rs   = modelRegs[ins[10:8]];
            rt   = modelRegs[ins[7:5]];
            se5  = {{11{ins[4]}}, ins[4:0]};
            ze5  = {11'd0, ins[4:0]};
            se8  = {{8{ins[7]}}, ins[7:0]};
            addr = rs + se5;
            dst  = ins[7:5];
            val  = '0;
            wr   = 1'b1;
            pc   = pc + 16'd2;
            case (ins[15:11])
                HALT: begin
                    wr   = 1'b0;
                    done = 1'b1;
                end
                NOP: wr = 1'b0;
                J: begin
                    wr = 1'b0;
                    pc = pc + {{5{ins[10]}}, ins[10:0]};
                end
                ADDI:  val = rs + se5;
                SUBI:  val = se5 - rs;
                XORI:  val = rs ^ ze5;
                ANDNI: val = rs & ~ze5;
                BEQZ, BNEZ: begin
                    wr = 1'b0;
                    if ((rs == 16'd0) == (ins[15:11] == BEQZ)) begin
                        pc = pc + se8;
                    end
                end
                ST: begin
                    wr = 1'b0;
                    modelMem[addr[8:1]] = rt;
                end
                LD: val = modelMem[addr[8:1]];
                LBI: begin
                    dst = ins[10:8];
                    val = se8;
                end
                RRR: begin
                    dst = ins[4:2];
                    case (ins[1:0])
                        2'b00:   val = rs + rt;
                        2'b01:   val = rt - rs;
                        2'b10:   val = rs ^ rt;
                        default: val = rs & ~rt;
                    endcase
                end
                default: begin
                    wr     = 1'b0;
                    expErr = 1'b1;
                    done   = 1'b1;
                end
            endcase
            if (wr) begin
                modelRegs[dst] = val;
                expTrace.push_back({dst, val});
            end
            pc = {pc[15:1], 1'b0};
            steps++;
        end
    endtask

    task automatic loadProgram();
        for (int i = 0; i < progWords; i++) begin
            @(negedge clk);
            loadEn   = 1'b1;
            loadAddr = 16'(i);
            loadData = prog[i];
            expectEqual("err while loading", 16'(err), 16'd0);
            expectEqual("halted while loading", 16'(halted), 16'd0);
            expectEqual("wbValid while loading", 16'(wbValid), 16'd0);
        end
        @(negedge clk);
        loadEn = 1'b0;
    endtask

    // Follows the retire trace until halted and samples after the falling edge
    task automatic runProgram();
        int          cycles;
        logic [18:0] exp;
        @(negedge clk);
        run = 1'b1;
        cycles = 0;
        #1;
        while (!halted && cycles < maxCycles) begin
            if (wbValid) begin
                if (expTrace.size() == 0) begin
                    abortRun("Retire trace shows a register write that the model does not expect");
                end else begin
                    exp = expTrace.pop_front();
                    expectEqual("wbReg", 16'(wbReg), 16'(exp[18:16]));
                    expectEqual("wbData", wbData, exp[15:0]);
                end
            end
            cycles++;
            @(negedge clk);
            #1;
        end
        if (!halted) begin
            abortRun("Timed out waiting for the core to halt");
        end else begin
            expectEqual("missing trace entries", 16'(expTrace.size()), 16'd0);
            expectEqual("err at halt", 16'(err), 16'(expErr));
            repeat (3) begin
                @(negedge clk);
                #1;
                expectEqual("halted after halt", 16'(halted), 16'd1);
                expectEqual("wbValid after halt", 16'(wbValid), 16'd0);
            end
        end
    endtask

    task automatic stopRun();
        int cycles;
        @(negedge clk);
        run = 1'b0;
        cycles = 0;
        @(negedge clk);
        while (halted && cycles < 10) begin
            @(negedge clk);
            cycles++;
        end
        if (halted) begin
            abortRun("Halted did not clear after run went low");
        end
    endtask

    initial begin
        rst      = 1'b1;
        run      = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        rngState = 32'd7;
        for (int r = 0; r < regCount; r++) begin
            modelRegs[r] = '0;
        end
        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        expectEqual("err after reset", 16'(err), 16'd0);
        expectEqual("halted after reset", 16'(halted), 16'd0);
        expectEqual("wbValid after reset", 16'(wbValid), 16'd0);

        // Data memory gets known contents before any load
        genMemInit();
        runModel();
        loadProgram();
        runProgram();
        stopRun();

        for (int p = 0; p < numPrograms; p++) begin
            genProgram(progLength, {HALT, 11'd0});
            runModel();
            loadProgram();
            runProgram();
            stopRun();
        end

        // Illegal opcode inside the program and in all the padding
        genProgram(progLength, {illegalOpcode(), 11'd0});
        prog[randBelow(progLength)] = {illegalOpcode(), 11'd0};
        runModel();
        loadProgram();
        runProgram();
        expectEqual("err after illegal opcode", 16'(err), 16'd1);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
hdl/procPkg.sv
hdl/ctrlIf.sv
hdl/fetch.sv
hdl/control.sv
hdl/decode.sv
hdl/execute.sv
hdl/memStage.sv
hdl/pcControl.sv
hdl/proc.sv
testbench/proc_props.sv
testbench/tb_proc.sv

// ==== Makefile ====
TOP = tb_proc

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build folder"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) \
		-f filelist.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
